//--- common/rvv_alu_pkg.sv
package rvv_alu_pkg;

  // vector register length in bits
  localparam int unsigned VLEN = 128;

  // scalar result width for vcpop
  localparam int unsigned XLEN = 32;

  // elements per prefix half
  localparam int unsigned HALF_LEN = VLEN / 2;

  // element widths
  localparam int unsigned BYTE_WIDTH  = 8;
  localparam int unsigned HWORD_WIDTH = 16;
  localparam int unsigned WORD_WIDTH  = 32;

  // elements of each width in one register
  localparam int unsigned VLENB       = VLEN / BYTE_WIDTH;
  localparam int unsigned VLEN_HWORDS = VLEN / HWORD_WIDTH;
  localparam int unsigned VLEN_WORDS  = VLEN / WORD_WIDTH;

  // 8 uops cover a full EEW8 viota
  localparam int unsigned UOP_INDEX_WIDTH = 3;

  localparam int unsigned ROB_ENTRY_WIDTH = 4;

  // counts include the all-set case, hence the extra bit
  localparam int unsigned HALF_COUNT_WIDTH = $clog2(HALF_LEN) + 1;
  localparam int unsigned ELEM_COUNT_WIDTH = $clog2(VLEN) + 1;

  typedef logic [VLEN-1:0] vreg_t;

  typedef logic [ROB_ENTRY_WIDTH-1:0] rob_entry_t;

  typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;

  // 0 to 64 within one half
  typedef logic [HALF_COUNT_WIDTH-1:0] half_count_t;

  // 0 to 128 over the whole register
  typedef logic [ELEM_COUNT_WIDTH-1:0] elem_count_t;

  // destination element width
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_t;

  // mask alu sub-opcodes
  typedef enum logic [2:0] {
    OP_VMAND = 3'd0,
    OP_VMOR  = 3'd1,
    OP_VMXOR = 3'd2,
    OP_VCPOP = 3'd3,
    OP_VIOTA = 3'd4
  } alu_op_t;

endpackage

//--- alu_unit/rvv_alu_execution_p0.sv
`timescale 1ns/1ps

module rvv_alu_execution_p0 (
  input  logic                                                 clk,
  input  logic                                                 rst_n,

  // uop from dispatch
  input  logic                                                 uop_valid,
  input  rvv_alu_pkg::alu_op_t                                 uop_opcode,
  input  rvv_alu_pkg::eew_t                                    vd_eew,
  input  rvv_alu_pkg::uop_index_t                              uop_index,
  input  rvv_alu_pkg::vreg_t                                   vs1_mask,
  input  rvv_alu_pkg::vreg_t                                   vs2_mask,
  input  rvv_alu_pkg::vreg_t                                   v0_mask,
  input  logic                                                 vm,
  input  rvv_alu_pkg::rob_entry_t                              rob_entry,

  // registered stage toward p1
  output logic                                                 p1_valid,
  output rvv_alu_pkg::alu_op_t                                 p1_opcode,
  output rvv_alu_pkg::eew_t                                    p1_eew,
  output rvv_alu_pkg::uop_index_t                              p1_uop_index,
  output rvv_alu_pkg::rob_entry_t                              p1_rob_entry,
  output rvv_alu_pkg::vreg_t                                   p1_logic_data,
  output rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] p1_prefix_lo,
  output rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] p1_prefix_hi,
  output rvv_alu_pkg::half_count_t                             p1_total_lo,
  output rvv_alu_pkg::half_count_t                             p1_total_hi
);

  rvv_alu_pkg::vreg_t                                   active;
  rvv_alu_pkg::vreg_t                                   vs2_active;
  rvv_alu_pkg::vreg_t                                   logic_data;
  rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] prefix_lo;
  rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] prefix_hi;
  rvv_alu_pkg::half_count_t                             total_lo;
  rvv_alu_pkg::half_count_t                             total_hi;

  // unmasked uops see every element as active
  assign active = vm ? '1 : v0_mask;

  assign vs2_active = vs2_mask & active;

  // mask logical ops work on all bits regardless of activity
  always_comb begin
    case (uop_opcode)
      rvv_alu_pkg::OP_VMAND: begin
        logic_data = vs2_mask & vs1_mask;
      end
      rvv_alu_pkg::OP_VMOR: begin
        logic_data = vs2_mask | vs1_mask;
      end
      rvv_alu_pkg::OP_VMXOR: begin
        logic_data = vs2_mask ^ vs1_mask;
      end
      default: begin
        logic_data = '0;
      end
    endcase
  end

  // exclusive running counts, both halves side by side
  // so the 64-bit chains stay short ahead of the register
  always_comb begin
    rvv_alu_pkg::half_count_t run_lo;
    rvv_alu_pkg::half_count_t run_hi;

    run_lo = '0;
    run_hi = '0;
    for (int i = 0; i < rvv_alu_pkg::HALF_LEN; i++) begin
      prefix_lo[i] = run_lo;
      prefix_hi[i] = run_hi;
      run_lo = run_lo + rvv_alu_pkg::half_count_t'(vs2_active[i]);
      run_hi = run_hi + rvv_alu_pkg::half_count_t'(vs2_active[rvv_alu_pkg::HALF_LEN + i]);
    end
    total_lo = run_lo;
    total_hi = run_hi;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p1_valid <= 1'b0;
    end else begin
      p1_valid <= uop_valid;
    end
  end

  // payload only moves with a valid uop
  always_ff @(posedge clk) begin
    if (uop_valid) begin
      p1_opcode     <= uop_opcode;
      p1_eew        <= vd_eew;
      p1_uop_index  <= uop_index;
      p1_rob_entry  <= rob_entry;
      p1_logic_data <= logic_data;
      p1_prefix_lo  <= prefix_lo;
      p1_prefix_hi  <= prefix_hi;
      p1_total_lo   <= total_lo;
      p1_total_hi   <= total_hi;
    end
  end

endmodule

//--- alu_unit/rvv_alu_execution_p1.sv
`timescale 1ns/1ps

module rvv_alu_execution_p1 (
  input  logic                                                 p1_valid,
  input  rvv_alu_pkg::alu_op_t                                 p1_opcode,
  input  rvv_alu_pkg::eew_t                                    p1_eew,
  input  rvv_alu_pkg::uop_index_t                              p1_uop_index,
  input  rvv_alu_pkg::rob_entry_t                              p1_rob_entry,
  input  rvv_alu_pkg::vreg_t                                   p1_logic_data,
  input  rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] p1_prefix_lo,
  input  rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] p1_prefix_hi,
  input  rvv_alu_pkg::half_count_t                             p1_total_lo,
  input  rvv_alu_pkg::half_count_t                             p1_total_hi,

  // result toward the rob
  output logic                                                 result_valid,
  output rvv_alu_pkg::rob_entry_t                              result_rob_entry,
  output rvv_alu_pkg::vreg_t                                   result_data
);

  rvv_alu_pkg::elem_count_t [rvv_alu_pkg::VLEN-1:0] viota_table;
  rvv_alu_pkg::elem_count_t                         vcpop_count;
  logic [rvv_alu_pkg::XLEN-1:0]                     result_vcpop;
  rvv_alu_pkg::vreg_t                               viota8;
  rvv_alu_pkg::vreg_t                               viota16;
  rvv_alu_pkg::vreg_t                               viota32;
  rvv_alu_pkg::vreg_t                               viota_packed;

  // upper half is offset by everything counted below element 64
  for (genvar j = 0; j < rvv_alu_pkg::HALF_LEN; j++) begin : g_viota_table
    assign viota_table[j] = rvv_alu_pkg::elem_count_t'(p1_prefix_lo[j]);
    assign viota_table[rvv_alu_pkg::HALF_LEN + j] =
      rvv_alu_pkg::elem_count_t'(p1_prefix_hi[j]) + rvv_alu_pkg::elem_count_t'(p1_total_lo);
  end

  assign vcpop_count  = rvv_alu_pkg::elem_count_t'(p1_total_lo) +
                        rvv_alu_pkg::elem_count_t'(p1_total_hi);
  assign result_vcpop = rvv_alu_pkg::XLEN'(vcpop_count);

  // uop_index picks which slice of the table lands in vd
  for (genvar j = 0; j < rvv_alu_pkg::VLENB; j++) begin : g_viota8
    assign viota8[j*rvv_alu_pkg::BYTE_WIDTH +: rvv_alu_pkg::BYTE_WIDTH] =
      viota_table[{p1_uop_index, 4'(j)}];
  end

  for (genvar j = 0; j < rvv_alu_pkg::VLEN_HWORDS; j++) begin : g_viota16
    assign viota16[j*rvv_alu_pkg::HWORD_WIDTH +: rvv_alu_pkg::HWORD_WIDTH] =
      rvv_alu_pkg::HWORD_WIDTH'(viota_table[{1'b0, p1_uop_index, 3'(j)}]);
  end

  for (genvar j = 0; j < rvv_alu_pkg::VLEN_WORDS; j++) begin : g_viota32
    assign viota32[j*rvv_alu_pkg::WORD_WIDTH +: rvv_alu_pkg::WORD_WIDTH] =
      rvv_alu_pkg::WORD_WIDTH'(viota_table[{2'b00, p1_uop_index, 2'(j)}]);
  end

  always_comb begin
    case (p1_eew)
      rvv_alu_pkg::EEW16: begin
        viota_packed = viota16;
      end
      rvv_alu_pkg::EEW32: begin
        viota_packed = viota32;
      end
      default: begin
        viota_packed = viota8;
      end
    endcase
  end

  // logical result passes through unless a count op overrides it
  always_comb begin
    case (p1_opcode)
      rvv_alu_pkg::OP_VCPOP: begin
        result_data = rvv_alu_pkg::vreg_t'(result_vcpop);
      end
      rvv_alu_pkg::OP_VIOTA: begin
        result_data = viota_packed;
      end
      default: begin
        result_data = p1_logic_data;
      end
    endcase
  end

  assign result_valid     = p1_valid;
  assign result_rob_entry = p1_rob_entry;

endmodule

//--- source/rvv_alu_unit.sv
`timescale 1ns/1ps

module rvv_alu_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  input  rvv_alu_pkg::alu_op_t    uop_opcode,
  input  rvv_alu_pkg::eew_t       vd_eew,
  input  rvv_alu_pkg::uop_index_t uop_index,
  input  rvv_alu_pkg::vreg_t      vs1_mask,
  input  rvv_alu_pkg::vreg_t      vs2_mask,
  input  rvv_alu_pkg::vreg_t      v0_mask,
  input  logic                    vm,
  input  rvv_alu_pkg::rob_entry_t rob_entry,
  output logic                    result_valid,
  output rvv_alu_pkg::rob_entry_t result_rob_entry,
  output rvv_alu_pkg::vreg_t      result_data
);

  // p0 to p1 stage register outputs
  logic                                                 p1_valid;
  rvv_alu_pkg::alu_op_t                                 p1_opcode;
  rvv_alu_pkg::eew_t                                    p1_eew;
  rvv_alu_pkg::uop_index_t                              p1_uop_index;
  rvv_alu_pkg::rob_entry_t                              p1_rob_entry;
  rvv_alu_pkg::vreg_t                                   p1_logic_data;
  rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] p1_prefix_lo;
  rvv_alu_pkg::half_count_t [rvv_alu_pkg::HALF_LEN-1:0] p1_prefix_hi;
  rvv_alu_pkg::half_count_t                             p1_total_lo;
  rvv_alu_pkg::half_count_t                             p1_total_hi;

  rvv_alu_execution_p0 u_p0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop_valid     (uop_valid),
    .uop_opcode    (uop_opcode),
    .vd_eew        (vd_eew),
    .uop_index     (uop_index),
    .vs1_mask      (vs1_mask),
    .vs2_mask      (vs2_mask),
    .v0_mask       (v0_mask),
    .vm            (vm),
    .rob_entry     (rob_entry),
    .p1_valid      (p1_valid),
    .p1_opcode     (p1_opcode),
    .p1_eew        (p1_eew),
    .p1_uop_index  (p1_uop_index),
    .p1_rob_entry  (p1_rob_entry),
    .p1_logic_data (p1_logic_data),
    .p1_prefix_lo  (p1_prefix_lo),
    .p1_prefix_hi  (p1_prefix_hi),
    .p1_total_lo   (p1_total_lo),
    .p1_total_hi   (p1_total_hi)
  );

  rvv_alu_execution_p1 u_p1 (
    .p1_valid         (p1_valid),
    .p1_opcode        (p1_opcode),
    .p1_eew           (p1_eew),
    .p1_uop_index     (p1_uop_index),
    .p1_rob_entry     (p1_rob_entry),
    .p1_logic_data    (p1_logic_data),
    .p1_prefix_lo     (p1_prefix_lo),
    .p1_prefix_hi     (p1_prefix_hi),
    .p1_total_lo      (p1_total_lo),
    .p1_total_hi      (p1_total_hi),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

//--- verif/rvv_alu_unit_properties.sv
`timescale 1ns/1ps

module rvv_alu_unit_properties (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    uop_valid,
  input logic                    result_valid,
  input rvv_alu_pkg::rob_entry_t result_rob_entry,
  input rvv_alu_pkg::vreg_t      result_data
);

  a_valid_low_in_reset: assert property (
    @(posedge clk) !rst_n |-> !result_valid
  ) else $error("result_valid high while reset is active");

  // fixed latency of one clock
  a_valid_follows_uop: assert property (
    @(posedge clk) disable iff (!rst_n) result_valid == $past(uop_valid)
  ) else $error("result_valid does not follow uop_valid by one cycle");

  a_result_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    result_valid |-> !$isunknown({result_data, result_rob_entry})
  ) else $error("result_data or result_rob_entry unknown with result_valid high");

endmodule

bind rvv_alu_unit rvv_alu_unit_properties u_properties (
  .clk              (clk),
  .rst_n            (rst_n),
  .uop_valid        (uop_valid),
  .result_valid     (result_valid),
  .result_rob_entry (result_rob_entry),
  .result_data      (result_data)
);

//--- verif/rvv_alu_unit_tb.sv
`timescale 1ns/1ps

module rvv_alu_unit_tb;

  localparam int unsigned CLK_PERIOD     = 20;
  localparam int unsigned RESET_CYCLES   = 8;
  localparam int unsigned DIRECTED_STEPS = 100;
  localparam int unsigned RANDOM_STEPS   = 400;
  localparam int unsigned MARGIN_CYCLES  = 50;
  localparam int unsigned TIMEOUT_NS     =
    (RESET_CYCLES + DIRECTED_STEPS + RANDOM_STEPS + MARGIN_CYCLES) * CLK_PERIOD;

  logic                    clk;
  logic                    rst_n;
  logic                    uop_valid;
  rvv_alu_pkg::alu_op_t    uop_opcode;
  rvv_alu_pkg::eew_t       vd_eew;
  rvv_alu_pkg::uop_index_t uop_index;
  rvv_alu_pkg::vreg_t      vs1_mask;
  rvv_alu_pkg::vreg_t      vs2_mask;
  rvv_alu_pkg::vreg_t      v0_mask;
  logic                    vm;
  rvv_alu_pkg::rob_entry_t rob_entry;
  logic                    result_valid;
  rvv_alu_pkg::rob_entry_t result_rob_entry;
  rvv_alu_pkg::vreg_t      result_data;

  // one-deep model pipeline, matches the fixed latency
  logic                    exp_valid;
  rvv_alu_pkg::vreg_t      exp_data;
  rvv_alu_pkg::rob_entry_t exp_rob;
  rvv_alu_pkg::rob_entry_t rob_tag;
  logic [31:0]             lcg_state;

  rvv_alu_unit u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .uop_opcode       (uop_opcode),
    .vd_eew           (vd_eew),
    .uop_index        (uop_index),
    .vs1_mask         (vs1_mask),
    .vs2_mask         (vs2_mask),
    .v0_mask          (v0_mask),
    .vm               (vm),
    .rob_entry        (rob_entry),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (next_rand() >> 8) % n;
  endfunction

  function automatic rvv_alu_pkg::vreg_t rand_vreg();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // mostly random, with some all-ones and all-zeros corners
  function automatic rvv_alu_pkg::vreg_t rand_mask();
    int unsigned mode;
    mode = rand_below(8);
    if (mode == 0) begin
      return '1;
    end else if (mode == 1) begin
      return '0;
    end
    return rand_vreg();
  endfunction

  function automatic rvv_alu_pkg::vreg_t expected_result(
    input rvv_alu_pkg::alu_op_t op, input rvv_alu_pkg::eew_t eew,
    input rvv_alu_pkg::uop_index_t idx, input rvv_alu_pkg::vreg_t vs1,
    input rvv_alu_pkg::vreg_t vs2, input rvv_alu_pkg::vreg_t v0, input logic vm_bit
  );
    rvv_alu_pkg::vreg_t res;
    int                 below [rvv_alu_pkg::VLEN+1];
    int                 width;
    int                 per_reg;
    int                 elem;

    // below[i] counts active set vs2 bits under element i
    below[0] = 0;
    for (int i = 0; i < rvv_alu_pkg::VLEN; i++) begin
      if (vs2[i] && (vm_bit || v0[i])) begin
        below[i+1] = below[i] + 1;
      end else begin
        below[i+1] = below[i];
      end
    end
    res = '0;
    case (op)
      rvv_alu_pkg::OP_VMAND: res = vs2 & vs1;
      rvv_alu_pkg::OP_VMOR:  res = vs2 | vs1;
      rvv_alu_pkg::OP_VMXOR: res = vs2 ^ vs1;
      rvv_alu_pkg::OP_VCPOP: res = rvv_alu_pkg::vreg_t'(below[rvv_alu_pkg::VLEN]);
      rvv_alu_pkg::OP_VIOTA: begin
        case (eew)
          rvv_alu_pkg::EEW16: width = 16;
          rvv_alu_pkg::EEW32: width = 32;
          default:            width = 8;
        endcase
        per_reg = rvv_alu_pkg::VLEN / width;
        for (int j = 0; j < per_reg; j++) begin
          elem = int'(idx) * per_reg + j;
          if (elem < int'(rvv_alu_pkg::VLEN)) begin
            for (int b = 0; b < width; b++) begin
              res[j*width + b] = below[elem][b];
            end
          end
        end
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("error at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_data(input rvv_alu_pkg::vreg_t got, input rvv_alu_pkg::vreg_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("result_data %h, expected %h", got, exp));
    end
  endtask

  task automatic check_rob(input rvv_alu_pkg::rob_entry_t got,
                           input rvv_alu_pkg::rob_entry_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("result_rob_entry %0d, expected %0d", got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("result_valid %b, expected %b", got, exp));
    end
  endtask

  // check the previous uop's result, then present the next one
  task automatic step(
    input logic valid, input rvv_alu_pkg::alu_op_t op, input rvv_alu_pkg::eew_t eew,
    input rvv_alu_pkg::uop_index_t idx, input rvv_alu_pkg::vreg_t vs1,
    input rvv_alu_pkg::vreg_t vs2, input rvv_alu_pkg::vreg_t v0, input logic vm_bit
  );
    @(negedge clk);
    check_valid(result_valid, exp_valid);
    if (exp_valid) begin
      check_data(result_data, exp_data);
      check_rob(result_rob_entry, exp_rob);
    end
    uop_valid  = valid;
    uop_opcode = op;
    vd_eew     = eew;
    uop_index  = idx;
    vs1_mask   = vs1;
    vs2_mask   = vs2;
    v0_mask    = v0;
    vm         = vm_bit;
    rob_entry  = rob_tag;
    exp_valid  = valid;
    if (valid) begin
      exp_data = expected_result(op, eew, idx, vs1, vs2, v0, vm_bit);
      exp_rob  = rob_tag;
      rob_tag  = rob_tag + rvv_alu_pkg::rob_entry_t'(1);
    end
  endtask

  // junk operands on idle cycles must not matter
  task automatic idle_cycle();
    step(1'b0, rvv_alu_pkg::OP_VMAND, rvv_alu_pkg::EEW8, '0,
         rand_vreg(), rand_vreg(), rand_vreg(), 1'b0);
  endtask

  initial begin
    rvv_alu_pkg::vreg_t   a;
    rvv_alu_pkg::vreg_t   b;
    rvv_alu_pkg::vreg_t   c;
    rvv_alu_pkg::alu_op_t op;
    rvv_alu_pkg::eew_t    eew;
    logic                 vm_bit;

    lcg_state  = 32'hc5a1_9a56;
    rst_n      = 1'b0;
    uop_valid  = 1'b0;
    uop_opcode = rvv_alu_pkg::OP_VMAND;
    vd_eew     = rvv_alu_pkg::EEW8;
    uop_index  = '0;
    vs1_mask   = '0;
    vs2_mask   = '0;
    v0_mask    = '0;
    vm         = 1'b1;
    rob_entry  = '0;
    exp_valid  = 1'b0;
    exp_data   = '0;
    exp_rob    = '0;
    rob_tag    = '0;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_valid(result_valid, 1'b0);
    end
    rst_n = 1'b1;
    repeat (4) idle_cycle();

    for (int k = 0; k < 4; k++) begin
      a = rand_mask();
      b = rand_mask();
      step(1'b1, rvv_alu_pkg::OP_VMAND, rvv_alu_pkg::EEW8, '0, a, b, '0, 1'b1);
      step(1'b1, rvv_alu_pkg::OP_VMOR, rvv_alu_pkg::EEW16, '0, a, b, '0, 1'b0);
      step(1'b1, rvv_alu_pkg::OP_VMXOR, rvv_alu_pkg::EEW32, '0, a, b, '0, 1'b1);
    end
    idle_cycle();

    // full count of 128, then a fully masked-off source
    step(1'b1, rvv_alu_pkg::OP_VCPOP, rvv_alu_pkg::EEW8, '0, '0, '1, '0, 1'b1);
    step(1'b1, rvv_alu_pkg::OP_VCPOP, rvv_alu_pkg::EEW8, '0, '0, '1, '1, 1'b0);
    step(1'b1, rvv_alu_pkg::OP_VCPOP, rvv_alu_pkg::EEW8, '0, '0, '1, '0, 1'b0);
    for (int k = 0; k < 4; k++) begin
      step(1'b1, rvv_alu_pkg::OP_VCPOP, rvv_alu_pkg::EEW8, '0, '0, rand_vreg(), '0, 1'b1);
      a = rand_vreg();
      b = rand_vreg();
      step(1'b1, rvv_alu_pkg::OP_VCPOP, rvv_alu_pkg::EEW8, '0, '0, a, b, 1'b0);
    end
    idle_cycle();

    for (int e = 0; e < 3; e++) begin
      for (int m = 0; m < 2; m++) begin
        eew = rvv_alu_pkg::eew_t'(2'(e));
        a   = rand_vreg();
        b   = rand_vreg();
        for (int u = 0; u < 8; u++) begin
          step(1'b1, rvv_alu_pkg::OP_VIOTA, eew, rvv_alu_pkg::uop_index_t'(u),
               '0, a, b, m == 0);
        end
      end
    end
    // all ones gives the largest counts across element 64
    for (int u = 0; u < 8; u++) begin
      step(1'b1, rvv_alu_pkg::OP_VIOTA, rvv_alu_pkg::EEW8, rvv_alu_pkg::uop_index_t'(u),
           '0, '1, '0, 1'b1);
    end
    idle_cycle();

    for (int k = 0; k < 8; k++) begin
      op = rvv_alu_pkg::alu_op_t'(3'(k % 5));
      step(1'b1, op, rvv_alu_pkg::EEW16, rvv_alu_pkg::uop_index_t'(k),
           rand_vreg(), rand_vreg(), rand_vreg(), k[0]);
    end

    for (int n = 0; n < RANDOM_STEPS; n++) begin
      if (rand_below(4) == 0) begin
        idle_cycle();
      end else begin
        op     = rvv_alu_pkg::alu_op_t'(3'(rand_below(5)));
        eew    = rvv_alu_pkg::eew_t'(2'(rand_below(3)));
        a      = rand_mask();
        b      = rand_mask();
        c      = rand_mask();
        vm_bit = rand_below(2) == 1;
        step(1'b1, op, eew, rvv_alu_pkg::uop_index_t'(rand_below(8)), a, b, c, vm_bit);
      end
    end
    idle_cycle();
    idle_cycle();

    $display("All tests passed!");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the test did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

endmodule

//--- all.f
common/rvv_alu_pkg.sv
alu_unit/rvv_alu_execution_p0.sv
alu_unit/rvv_alu_execution_p1.sv
source/rvv_alu_unit.sv
verif/rvv_alu_unit_properties.sv
verif/rvv_alu_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvv_alu_unit_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All tests passed!
FAIL_MSG  := Test failures found

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the verdict; a missing pass line counts as a failure
run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
